/* sdio_pkg.sv */
/*
  SDIO data path package
  Register map, field widths, CRC constants and the packed structs
  shared by the register block and the 4-bit data phy
*/
package sdio_pkg;

  // Block length in bytes
  localparam int SDIO_BLK_LEN_W = 12;

  // CRC16 on each DAT line, x^16 + x^12 + x^5 + 1
  localparam int SDIO_CRC_W = 16;
  localparam logic [SDIO_CRC_W-1:0] SDIO_CRC_POLY = 16'h1021;

  // Register addresses
  localparam logic [1:0] SDIO_ADDR_CTRL   = 2'd0;
  localparam logic [1:0] SDIO_ADDR_BLKLEN = 2'd1;
  localparam logic [1:0] SDIO_ADDR_STATUS = 2'd2;

  // Transfer configuration, held steady while busy
  typedef struct packed {
    logic                      tx_dir;
    logic [SDIO_BLK_LEN_W-1:0] blk_len;
  } sdio_cfg_t;

  // Status as read back from the STATUS register
  // done is sticky until the next start, crc_ok is valid once done is set
  typedef struct packed {
    logic busy;
    logic done;
    logic crc_ok;
  } sdio_status_t;

  // Drive side of the four DAT lines
  typedef struct packed {
    logic       oe;
    logic [3:0] dat;
  } sdio_dat_t;

  // Single register write from the host bus
  typedef struct packed {
    logic [1:0]  addr;
    logic [15:0] data;
  } sdio_reg_wr_t;

endpackage

/* sdio_crc16.sv */
/*
  Serial CRC16 for one SD DAT line
  Shifts in one bit per enabled cycle, cleared to zero before each block
*/
`timescale 1ns/1ps

module sdio_crc16 (
  input  logic                          clk,
  input  logic                          i_clear,
  input  logic                          i_en,
  input  logic                          i_bit,
  output logic [sdio_pkg::SDIO_CRC_W-1:0] o_crc
);
  import sdio_pkg::*;

  logic feedback;

  assign feedback = o_crc[SDIO_CRC_W-1] ^ i_bit;

  // Galois form LFSR, clear wins over enable
  always_ff @(posedge clk) begin
    if (i_clear) begin
      o_crc <= '0;
    end else if (i_en) begin
      if (feedback) begin
        o_crc <= {o_crc[SDIO_CRC_W-2:0], 1'b0} ^ SDIO_CRC_POLY;
      end else begin
        o_crc <= {o_crc[SDIO_CRC_W-2:0], 1'b0};
      end
    end
  end

endmodule

/* sdio_data_regs.sv */
/*
  SDIO data register block
  Holds block length and direction, turns a CTRL start write into a
  one-cycle strobe and keeps sticky done and CRC status for the host
*/
`timescale 1ns/1ps

module sdio_data_regs (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_reg_stb,
  input  sdio_pkg::sdio_reg_wr_t i_reg_wr,
  input  logic [1:0]             i_rd_addr,
  output logic [15:0]            o_rd_data,
  input  logic                   i_busy,
  input  logic                   i_done,
  input  logic                   i_crc_ok,
  output logic                   o_start,
  output sdio_pkg::sdio_cfg_t    o_cfg
);
  import sdio_pkg::*;

  logic         busy;
  logic         wr_ok;
  logic         start_wr;
  logic         done_q;
  logic         crc_ok_q;
  sdio_status_t status;

  // Busy already in the strobe cycle, before the phy leaves idle
  assign busy     = o_start | i_busy;
  assign wr_ok    = i_reg_stb & ~busy;
  assign start_wr = wr_ok && (i_reg_wr.addr == SDIO_ADDR_CTRL) && i_reg_wr.data[0];

  always_ff @(posedge clk) begin
    if (rst) begin
      o_start  <= 1'b0;
      o_cfg    <= '0;
      done_q   <= 1'b0;
      crc_ok_q <= 1'b0;
    end else begin
      o_start <= start_wr;
      if (wr_ok) begin
        case (i_reg_wr.addr)
          SDIO_ADDR_CTRL:   o_cfg.tx_dir  <= i_reg_wr.data[1];
          SDIO_ADDR_BLKLEN: o_cfg.blk_len <= i_reg_wr.data[SDIO_BLK_LEN_W-1:0];
          default: ;
        endcase
      end
      // A new start clears the previous result
      if (start_wr) begin
        done_q   <= 1'b0;
        crc_ok_q <= 1'b0;
      end else if (i_done) begin
        done_q   <= 1'b1;
        crc_ok_q <= i_crc_ok;
      end
    end
  end

  assign status = '{busy: busy, done: done_q, crc_ok: crc_ok_q};

  // Read data, unused bits are zero
  always_comb begin
    o_rd_data = '0;
    case (i_rd_addr)
      SDIO_ADDR_CTRL:   o_rd_data[1] = o_cfg.tx_dir;
      SDIO_ADDR_BLKLEN: o_rd_data[SDIO_BLK_LEN_W-1:0] = o_cfg.blk_len;
      SDIO_ADDR_STATUS: o_rd_data[2:0] = status;
      default:          o_rd_data = '0;
    endcase
  end

endmodule

/* sdio_data_phy.sv */
/*
  SDIO 4-bit data phy
  One block per start: start bit, nibbles high first, per-line CRC16
  and end bit, either driven onto the DAT lines or checked on receive
*/
`timescale 1ns/1ps

module sdio_data_phy (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_start,
  input  sdio_pkg::sdio_cfg_t i_cfg,
  output logic                o_busy,
  output logic                o_done,
  output logic                o_crc_ok,
  output logic                o_tx_req,
  input  logic [7:0]          i_tx_byte,
  output logic                o_rx_stb,
  output logic [7:0]          o_rx_byte,
  input  logic [3:0]          i_dat,
  output sdio_pkg::sdio_dat_t o_dat
);
  import sdio_pkg::*;

  localparam int NIB_W = SDIO_BLK_LEN_W + 1;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WAIT_START,
    ST_START_BIT,
    ST_DATA,
    ST_CRC,
    ST_END_BIT,
    ST_FINISH
  } state_t;

  state_t                state;
  logic                  tx;
  logic                  start_acc;
  logic [NIB_W-1:0]      nib_total;
  logic [NIB_W-1:0]      nib_cnt;
  logic                  last_nib;
  logic [3:0]            crc_cnt;
  logic                  crc_ok_q;
  logic [3:0]            hi_nib;
  logic [3:0]            crc_bit_in;
  logic [3:0]            crc_tx_bits;
  logic [3:0]            crc_match;
  logic [SDIO_CRC_W-1:0] crc_val [4];
  logic [SDIO_CRC_W-1:0] crc_rx [4];

  assign tx        = i_cfg.tx_dir;
  assign start_acc = (state == ST_IDLE) && i_start;
  assign nib_total = {i_cfg.blk_len, 1'b0};
  assign last_nib  = (nib_cnt == nib_total - 1'b1);

  // Transmit hashes what goes out, receive what comes in
  assign crc_bit_in = tx ? o_dat.dat : i_dat;

  generate
    for (genvar g = 0; g < 4; g++) begin : g_line
      sdio_crc16 crc_inst (
        .clk     (clk),
        .i_clear (start_acc),
        .i_en    (state == ST_DATA),
        .i_bit   (crc_bit_in[g]),
        .o_crc   (crc_val[g])
      );

      // CRC is frozen after the data, so the counter indexes it out MSB first
      assign crc_tx_bits[g] = crc_val[g][~crc_cnt];

      // Received CRC bits for this line
      always_ff @(posedge clk) begin
        if (state == ST_CRC) begin
          crc_rx[g] <= {crc_rx[g][SDIO_CRC_W-2:0], i_dat[g]};
        end
      end

      assign crc_match[g] = (crc_rx[g] == crc_val[g]);
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= ST_IDLE;
      nib_cnt  <= '0;
      crc_cnt  <= '0;
      crc_ok_q <= 1'b0;
      o_rx_stb <= 1'b0;
    end else begin
      o_rx_stb <= (state == ST_DATA) && !tx && nib_cnt[0];
      case (state)
        ST_IDLE: begin
          nib_cnt <= '0;
          crc_cnt <= '0;
          if (i_start) begin
            state <= tx ? ST_START_BIT : ST_WAIT_START;
          end
        end
        // Card start bit pulls all four lines low
        ST_WAIT_START: begin
          if (i_dat == 4'h0) begin
            state <= ST_DATA;
          end
        end
        ST_START_BIT: begin
          state <= ST_DATA;
        end
        ST_DATA: begin
          nib_cnt <= nib_cnt + 1'b1;
          if (last_nib) begin
            state <= ST_CRC;
          end
        end
        ST_CRC: begin
          crc_cnt <= crc_cnt + 1'b1;
          if (crc_cnt == 4'd15) begin
            state <= ST_END_BIT;
          end
        end
        // A missing end bit still ends the block, as a CRC failure
        ST_END_BIT: begin
          crc_ok_q <= tx | ((&crc_match) && (i_dat == 4'hf));
          state    <= ST_FINISH;
        end
        ST_FINISH: begin
          state <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  // Receive byte assembly, high nibble first
  always_ff @(posedge clk) begin
    if ((state == ST_DATA) && !tx) begin
      if (!nib_cnt[0]) begin
        hi_nib <= i_dat;
      end else begin
        o_rx_byte <= {hi_nib, i_dat};
      end
    end
  end

  // Bus drive follows the state, lines idle high
  always_comb begin
    o_dat.oe  = 1'b0;
    o_dat.dat = 4'hf;
    if (tx) begin
      case (state)
        ST_START_BIT: begin
          o_dat.oe  = 1'b1;
          o_dat.dat = 4'h0;
        end
        ST_DATA: begin
          o_dat.oe  = 1'b1;
          o_dat.dat = nib_cnt[0] ? i_tx_byte[3:0] : i_tx_byte[7:4];
        end
        ST_CRC: begin
          o_dat.oe  = 1'b1;
          o_dat.dat = crc_tx_bits;
        end
        ST_END_BIT: begin
          o_dat.oe  = 1'b1;
          o_dat.dat = 4'hf;
        end
        default: ;
      endcase
    end
  end

  // Next byte wanted one cycle before its high nibble goes out
  assign o_tx_req = tx && ((state == ST_START_BIT) ||
                           ((state == ST_DATA) && nib_cnt[0] && !last_nib));

  assign o_busy   = (state != ST_IDLE);
  assign o_done   = (state == ST_FINISH);
  assign o_crc_ok = crc_ok_q;

endmodule

/* sdio_data_top.sv */
/*
  SDIO data path top level
  Register block feeding the 4-bit data phy
*/
`timescale 1ns/1ps

module sdio_data_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   i_reg_stb,
  input  sdio_pkg::sdio_reg_wr_t i_reg_wr,
  input  logic [1:0]             i_rd_addr,
  output logic [15:0]            o_rd_data,
  output logic                   o_tx_req,
  input  logic [7:0]             i_tx_byte,
  output logic                   o_rx_stb,
  output logic [7:0]             o_rx_byte,
  input  logic [3:0]             i_dat,
  output sdio_pkg::sdio_dat_t    o_dat
);
  import sdio_pkg::*;

  sdio_cfg_t cfg;
  logic      start;
  logic      busy;
  logic      done;
  logic      crc_ok;

  sdio_data_regs regs0 (
    .clk       (clk),
    .rst       (rst),
    .i_reg_stb (i_reg_stb),
    .i_reg_wr  (i_reg_wr),
    .i_rd_addr (i_rd_addr),
    .o_rd_data (o_rd_data),
    .i_busy    (busy),
    .i_done    (done),
    .i_crc_ok  (crc_ok),
    .o_start   (start),
    .o_cfg     (cfg)
  );

  sdio_data_phy phy0 (
    .clk       (clk),
    .rst       (rst),
    .i_start   (start),
    .i_cfg     (cfg),
    .o_busy    (busy),
    .o_done    (done),
    .o_crc_ok  (crc_ok),
    .o_tx_req  (o_tx_req),
    .i_tx_byte (i_tx_byte),
    .o_rx_stb  (o_rx_stb),
    .o_rx_byte (o_rx_byte),
    .i_dat     (i_dat),
    .o_dat     (o_dat)
  );

endmodule

/* sdio_data_checker.sv */
/*
  SDIO data phy protocol checker
  Concurrent assertions on the done strobe, the output enable and the start bit
*/
`timescale 1ns/1ps

module sdio_data_checker (
  input logic                clk,
  input logic                rst,
  input logic                i_busy,
  input logic                i_done,
  input logic                i_tx_req,
  input logic                i_tx_dir,
  input sdio_pkg::sdio_dat_t i_dat
);
  int fail_cnt = 0;

  // Done is a single-cycle strobe
  a_done_pulse: assert property (@(posedge clk) disable iff (rst) i_done |=> !i_done)
    else begin
      fail_cnt++;
      $error("o_done stayed high for more than one cycle");
    end

  // The host never drives the lines while receiving
  a_rx_no_oe: assert property (@(posedge clk) disable iff (rst)
                               (i_busy && !i_tx_dir) |-> !i_dat.oe)
    else begin
      fail_cnt++;
      $error("o_dat.oe high during a receive transfer");
    end

  // First driven cycle is the start bit, data follows directly
  a_start_bit: assert property (@(posedge clk) disable iff (rst)
                                $rose(i_dat.oe) |-> (i_dat.dat == 4'h0) && i_tx_req
                                                    ##1 i_dat.oe)
    else begin
      fail_cnt++;
      $error("start bit not all zeros or not followed by data");
    end

endmodule

/* tb_sdio_data.sv */
/*
  Testbench for the SDIO data path
  Plays the card on the DAT lines, feeds transmit bytes and checks frames,
  received bytes and status against a reference CRC16 per line
*/
`timescale 1ns/1ps

module tb_sdio_data;
  import sdio_pkg::*;

  localparam int MAX_LEN  = 64;
  localparam int N_XFER   = 8;
  localparam int XFER_CYC = 2 * MAX_LEN + 40;

  logic         clk;
  logic         rst;
  logic         i_reg_stb;
  sdio_reg_wr_t i_reg_wr;
  logic [1:0]   i_rd_addr;
  logic [15:0]  o_rd_data;
  logic         o_tx_req;
  logic [7:0]   i_tx_byte;
  logic         o_rx_stb;
  logic [7:0]   o_rx_byte;
  logic [3:0]   i_dat;
  sdio_dat_t    o_dat;

  logic [7:0] blk [MAX_LEN];
  logic [7:0] tx_q [$];
  logic [7:0] rx_exp_q [$];
  logic [7:0] rx_exp_byte;
  logic       tx_req_q;
  int         tx_req_cnt;
  int         rx_stb_cnt;
  int         errors;

  sdio_data_top dut0 (.*);

  bind sdio_data_phy sdio_data_checker chk0 (
    .clk(clk), .rst(rst), .i_busy(o_busy), .i_done(o_done),
    .i_tx_req(o_tx_req), .i_tx_dir(i_cfg.tx_dir), .i_dat(o_dat)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(N_XFER * XFER_CYC * 10 + 1000);
    $display("ERROR: watchdog expired, the test sequence did not complete");
    $display("TESTS FAILED");
    $finish;
  end

  // Per-line CRC16 over the block with x^16 + x^12 + x^5 + 1 from zero
  function automatic logic [15:0] ref_crc(input int line, input int len);
    logic [15:0] crc;
    logic        b;
    crc = 16'h0000;
    for (int i = 0; i < 2 * len; i++) begin
      b   = i[0] ? blk[i / 2][line] : blk[i / 2][line + 4];
      crc = {crc[14:0], 1'b0} ^ ((crc[15] ^ b) ? 16'h1021 : 16'h0000);
    end
    return crc;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("ERROR %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
  endtask

  // Byte source answers each request in the next cycle
  always @(posedge clk) begin
    tx_req_q <= o_tx_req;
    if (o_tx_req) tx_req_cnt++;
  end

  always @(negedge clk) begin
    if (tx_req_q && tx_q.size() > 0) i_tx_byte = tx_q.pop_front();
  end

  // Received bytes in order
  always @(posedge clk) begin
    if (o_rx_stb) begin
      rx_stb_cnt++;
      if (rx_exp_q.size() == 0) begin
        errors++;
        $display("ERROR %0t ns: receive strobe when no byte was expected", $time);
      end else begin
        rx_exp_byte = rx_exp_q.pop_front();
        if (o_rx_byte !== rx_exp_byte) report_mismatch("o_rx_byte", o_rx_byte, rx_exp_byte);
      end
    end
  end

  task automatic write_reg(input logic [1:0] wr_addr, input logic [15:0] wr_data);
    @(negedge clk);
    i_reg_stb = 1'b1;
    i_reg_wr  = '{addr: wr_addr, data: wr_data};
    @(negedge clk);
    i_reg_stb = 1'b0;
  endtask

  task automatic read_reg(input logic [1:0] rd_addr, output logic [15:0] rd_data);
    @(negedge clk);
    i_rd_addr = rd_addr;
    @(posedge clk);
    rd_data = o_rd_data;
    @(negedge clk);
    i_rd_addr = SDIO_ADDR_STATUS;
  endtask

  task automatic fill_block(input int len, input logic tx);
    tx_q.delete();
    rx_exp_q.delete();
    for (int i = 0; i < len; i++) begin
      blk[i] = 8'($urandom);
      if (tx) tx_q.push_back(blk[i]);
      else rx_exp_q.push_back(blk[i]);
    end
  endtask

  // Returns at the edge that closes the cycle with o_start high
  task automatic start_xfer(input int len, input logic tx);
    @(negedge clk);
    tx_req_cnt = 0;
    rx_stb_cnt = 0;
    write_reg(SDIO_ADDR_BLKLEN, 16'(len));
    write_reg(SDIO_ADDR_CTRL, {14'd0, tx, 1'b1});
    @(posedge clk);
    if (o_rd_data[2:1] !== 2'b10) report_mismatch("status at start", o_rd_data[2:1], 2'b10);
  endtask

  task automatic finish_xfer(input int len, input logic tx, input logic crc_ok);
    logic [15:0] st;
    int          n;
    n = 0;
    do begin
      @(posedge clk);
      st = o_rd_data;
      n++;
    end while (!st[1] && n < XFER_CYC);
    if (!st[1]) begin
      errors++;
      $display("ERROR %0t ns: transfer did not finish within %0d cycles", $time, XFER_CYC);
    end
    if (st[2:0] !== {2'b01, crc_ok}) report_mismatch("status", st[2:0], {2'b01, crc_ok});
    if (tx && tx_req_cnt != len) report_mismatch("tx request count", tx_req_cnt, len);
    if (!tx && rx_stb_cnt != len) report_mismatch("rx strobe count", rx_stb_cnt, len);
  endtask

  task automatic run_tx(input int len);
    logic [15:0] crc [4];
    logic [3:0]  nib;
    fill_block(len, 1'b1);
    for (int n = 0; n < 4; n++) crc[n] = ref_crc(n, len);
    start_xfer(len, 1'b1);
    @(posedge clk);
    if (o_dat !== 5'h10) report_mismatch("o_dat start bit", o_dat, 5'h10);
    for (int i = 0; i < 2 * len; i++) begin
      @(posedge clk);
      nib = i[0] ? blk[i / 2][3:0] : blk[i / 2][7:4];
      if (o_dat !== {1'b1, nib}) report_mismatch("o_dat data", o_dat, {1'b1, nib});
    end
    for (int j = 15; j >= 0; j--) begin
      @(posedge clk);
      nib = {crc[3][j], crc[2][j], crc[1][j], crc[0][j]};
      if (o_dat !== {1'b1, nib}) report_mismatch("o_dat crc", o_dat, {1'b1, nib});
    end
    @(posedge clk);
    if (o_dat !== 5'h1f) report_mismatch("o_dat end bit", o_dat, 5'h1f);
    @(posedge clk);
    if (o_dat.oe !== 1'b0) report_mismatch("o_dat.oe after frame", o_dat.oe, 1'b0);
    finish_xfer(len, 1'b1, 1'b1);
  endtask

  // Card side of a receive with an optional flipped CRC bit
  task automatic run_rx(input int len, input logic corrupt);
    logic [15:0] crc [4];
    int          line;
    int          bitpos;
    fill_block(len, 1'b0);
    for (int n = 0; n < 4; n++) crc[n] = ref_crc(n, len);
    line   = $urandom_range(3);
    bitpos = $urandom_range(15);
    if (corrupt) crc[line][bitpos] = ~crc[line][bitpos];
    start_xfer(len, 1'b0);
    repeat ($urandom_range(7)) @(posedge clk);
    @(negedge clk);
    i_dat = 4'h0;
    for (int i = 0; i < 2 * len; i++) begin
      @(negedge clk);
      i_dat = i[0] ? blk[i / 2][3:0] : blk[i / 2][7:4];
    end
    for (int j = 15; j >= 0; j--) begin
      @(negedge clk);
      i_dat = {crc[3][j], crc[2][j], crc[1][j], crc[0][j]};
    end
    @(negedge clk);
    i_dat = 4'hf;
    finish_xfer(len, 1'b0, !corrupt);
  endtask

  task automatic reg_test;
    logic [15:0] rd;
    write_reg(SDIO_ADDR_BLKLEN, 16'h00a5);
    read_reg(SDIO_ADDR_BLKLEN, rd);
    if (rd !== 16'h00a5) report_mismatch("BLKLEN", rd, 16'h00a5);
    write_reg(SDIO_ADDR_CTRL, 16'h0002);
    read_reg(SDIO_ADDR_CTRL, rd);
    if (rd !== 16'h0002) report_mismatch("CTRL", rd, 16'h0002);
    // Writes during the transfer must be dropped
    fork
      run_tx(8);
      begin
        do @(posedge clk); while (!o_rd_data[2]);
        write_reg(SDIO_ADDR_BLKLEN, 16'd3);
        write_reg(SDIO_ADDR_CTRL, 16'h0001);
      end
    join
    repeat (4) @(posedge clk);
    read_reg(SDIO_ADDR_STATUS, rd);
    if (rd !== 16'h0003) report_mismatch("STATUS after busy writes", rd, 16'h0003);
    read_reg(SDIO_ADDR_BLKLEN, rd);
    if (rd !== 16'd8) report_mismatch("BLKLEN after busy writes", rd, 16'd8);
    read_reg(SDIO_ADDR_CTRL, rd);
    if (rd !== 16'h0002) report_mismatch("CTRL after busy writes", rd, 16'h0002);
  endtask

  initial begin
    void'($urandom(32'h4714_59c3));
    errors     = 0;
    tx_req_q   = 1'b0;
    tx_req_cnt = 0;
    rx_stb_cnt = 0;
    rst        = 1'b1;
    i_reg_stb  = 1'b0;
    i_reg_wr   = '0;
    i_rd_addr  = SDIO_ADDR_STATUS;
    i_tx_byte  = 8'h00;
    i_dat      = 4'hf;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(posedge clk);
    if (o_dat !== 5'h0f) report_mismatch("o_dat after reset", o_dat, 5'h0f);
    if (o_rd_data !== 16'h0000) report_mismatch("status after reset", o_rd_data, 16'h0000);
    if (o_tx_req !== 1'b0) report_mismatch("o_tx_req after reset", o_tx_req, 1'b0);

    run_tx($urandom_range(MAX_LEN, 1));
    run_rx($urandom_range(MAX_LEN, 1), 1'b0);
    run_rx($urandom_range(MAX_LEN, 1), 1'b1);
    reg_test();
    // Shortest and longest blocks in alternating directions
    run_tx(1);
    run_rx(MAX_LEN, 1'b0);
    run_tx(MAX_LEN);
    run_rx(1, 1'b0);

    repeat (4) @(posedge clk);
    $display("Checks done: %0d errors, %0d assertion failures",
             errors, dut0.phy0.chk0.fail_cnt);
    if (errors == 0 && dut0.phy0.chk0.fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
sdio_pkg.sv
sdio_crc16.sv
sdio_data_regs.sv
sdio_data_phy.sv
sdio_data_top.sv
sdio_data_checker.sv
tb_sdio_data.sv
